// ==== design/sp_bram_settings.svh ====
// sp_bram build settings
`ifndef SP_BRAM_SETTINGS_SVH
`define SP_BRAM_SETTINGS_SVH

// bus address width
`define SPB_ADDR_W 32

// bus data width, four byte lanes
`define SPB_DATA_W 32

// words per lane, power of two
`define SPB_DEPTH 8192

// word address width, bits above the byte offset
`define SPB_WADDR_W $clog2(`SPB_DEPTH)

`endif

// ==== design/bus_pkg.sv ====
// bus side types
package bus_pkg;

    // direction of a bus command, taken from i_wr_en
    typedef enum logic
    {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_e;

    // access width classified from the byte-enable mask
    typedef enum logic [1:0]
    {
        SZ_BYTE = 2'd0,    // mask 0001
        SZ_HALF = 2'd1,    // mask 0011
        SZ_WORD = 2'd2,    // mask 1111
        SZ_BAD  = 2'd3     // any other mask
    } access_size_e;

    // offsets 0 and 2 only for halfwords, 0 only for words
    // bytes may sit at any offset

endpackage

// ==== design/bram_pkg.sv ====
// memory side types
package bram_pkg;

    // controller states
    typedef enum logic [1:0]
    {
        ST_ISSUE  = 2'd0,    // waiting for a command
        ST_RETIRE = 2'd1,    // lane access in flight
        ST_DONE   = 2'd2     // response held until enable drops
    } ctrl_state_e;

    // one write enable per byte lane
    // bit 0 is the lowest byte of the word
    typedef logic [3:0] lane_mask_t;

    // lane mask with no lane selected
    localparam lane_mask_t LANES_NONE = 4'b0000;

endpackage

// ==== design/lane_port_if.sv ====
// lane port bundle
`include "sp_bram_settings.svh"

interface lane_port_if
    import bram_pkg::*;
();

    lane_mask_t                 wren;       // per lane write enable
    logic [`SPB_WADDR_W-1:0]    word_addr;  // shared by all lanes
    logic [`SPB_DATA_W-1:0]     wdata;      // already steered to lanes
    logic [`SPB_DATA_W-1:0]     rdata;      // full word from the lanes

    // controller side, word address comes from the bus at the top
    modport ctrl (output wren, output word_addr, output wdata, input rdata);

    // lane RAM side
    modport mem (input wren, input word_addr, input wdata, output rdata);

    // read aligner only looks at the read word
    modport rd (input rdata);

endinterface

// ==== design/access_decode.sv ====
// access size and lane decode
`include "sp_bram_settings.svh"

module access_decode
    import bus_pkg::*,
           bram_pkg::*;
(
    input  logic [`SPB_DATA_W/8-1:0] i_be,
    input  logic [1:0]               i_offset,
    input  logic [`SPB_DATA_W-1:0]   i_wdata,
    output access_size_e             o_size,
    output lane_mask_t               o_lane_mask,
    output logic [`SPB_DATA_W-1:0]   o_wdata_steered,
    output logic                     o_legal
);

    access_size_e size;

    // classify by mask only
    always_comb
    begin
        case (i_be)
            4'b0001: size = SZ_BYTE;
            4'b0011: size = SZ_HALF;
            4'b1111: size = SZ_WORD;
            default: size = SZ_BAD;
        endcase
    end

    assign o_size = size;

    // offset check, lane select and data replication
    always_comb
    begin
        o_legal         = 1'b0;
        o_lane_mask     = LANES_NONE;
        o_wdata_steered = i_wdata;
        case (size)
            SZ_BYTE:
            begin
                o_legal         = 1'b1;                        // any offset
                o_lane_mask     = lane_mask_t'(4'b0001 << i_offset);
                o_wdata_steered = {4{i_wdata[7:0]}};
            end
            SZ_HALF:
            begin
                o_legal         = ~i_offset[0];
                o_lane_mask     = i_offset[1] ? 4'b1100 : 4'b0011;
                o_wdata_steered = {2{i_wdata[15:0]}};
            end
            SZ_WORD:
            begin
                o_legal     = (i_offset == 2'b00);
                o_lane_mask = 4'b1111;
            end
            default:
            begin
                // unsupported mask, nothing enabled
                o_legal     = 1'b0;
                o_lane_mask = LANES_NONE;
            end
        endcase

        if (!o_legal)
        begin
            o_lane_mask = LANES_NONE;   // refused access never touches a lane
        end
    end

endmodule

// ==== design/lane_bank.sv ====
// byte lane RAM bank
`include "sp_bram_settings.svh"

module lane_bank
(
    input logic          clk,
    lane_port_if.mem     lanes
);

    localparam int NUM_LANES = `SPB_DATA_W / 8;

    logic [7:0] lane_q [NUM_LANES];   // registered read byte per lane

    // one single-port array per lane, no byte enable inside a lane
    for (genvar l = 0; l < NUM_LANES; l++)
    begin : g_lane
        logic [7:0] ram [`SPB_DEPTH];

        always_ff @(posedge clk)
        begin
            if (lanes.wren[l])
            begin
                ram[lanes.word_addr] <= lanes.wdata[8*l +: 8];
            end
            lane_q[l] <= ram[lanes.word_addr];   // read every cycle
        end
    end

    // reassemble the word, lane 0 at the bottom
    assign lanes.rdata = {lane_q[3], lane_q[2], lane_q[1], lane_q[0]};

endmodule

// ==== design/read_align.sv ====
// read data alignment
`include "sp_bram_settings.svh"

module read_align
    import bus_pkg::*;
(
    input  access_size_e             i_size,
    input  logic [1:0]               i_offset,
    lane_port_if.rd                  lanes,
    output logic [`SPB_DATA_W-1:0]   o_rdata_aligned
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // byte picked by full offset
    always_comb
    begin
        case (i_offset)
            2'd0:    sel_byte = lanes.rdata[7:0];
            2'd1:    sel_byte = lanes.rdata[15:8];
            2'd2:    sel_byte = lanes.rdata[23:16];
            default: sel_byte = lanes.rdata[31:24];
        endcase
    end

    // halfword picked by offset bit 1 only
    assign sel_half = i_offset[1] ? lanes.rdata[31:16] : lanes.rdata[15:0];

    // zero-extend by size
    always_comb
    begin
        case (i_size)
            SZ_BYTE:
            begin
                o_rdata_aligned = {{(`SPB_DATA_W-8){1'b0}}, sel_byte};
            end
            SZ_HALF:
            begin
                o_rdata_aligned = {{(`SPB_DATA_W-16){1'b0}}, sel_half};
            end
            default:
            begin
                o_rdata_aligned = lanes.rdata;   // word, bad size never latched
            end
        endcase
    end

endmodule

// ==== design/sp_bram_ctrl.sv ====
// memory bus controller
`include "sp_bram_settings.svh"

module sp_bram_ctrl
    import bus_pkg::*,
           bram_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     i_enable,
    input  logic                     i_wr_en,
    input  logic                     i_legal,
    input  lane_mask_t               i_lane_mask,
    input  logic [`SPB_DATA_W-1:0]   i_wdata_steered,
    input  logic [`SPB_DATA_W-1:0]   i_rdata_aligned,
    output logic                     o_ready,
    output logic [`SPB_DATA_W-1:0]   o_rdata,
    output logic                     o_bus_err,
    lane_port_if.ctrl                lanes
);

    ctrl_state_e state;
    bus_op_e     op;
    logic        err_q;
    logic        start;

    assign op    = bus_op_e'(i_wr_en);
    assign start = (state == ST_ISSUE) && i_enable;

    // error only shown while the master still holds enable
    assign o_bus_err = err_q & i_enable;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state      <= ST_ISSUE;
            o_ready    <= 1'b0;
            err_q      <= 1'b0;
            o_rdata    <= '0;
            lanes.wren <= LANES_NONE;
        end
        else
        begin
            case (state)
                ST_ISSUE:
                begin
                    if (i_enable)
                    begin
                        if (!i_legal)
                        begin
                            // refused at once, memory untouched
                            o_ready <= 1'b1;
                            err_q   <= 1'b1;
                            state   <= ST_DONE;
                        end
                        else
                        begin
                            if (op == OP_WRITE)
                            begin
                                lanes.wren <= i_lane_mask;
                            end
                            state <= ST_RETIRE;   // lane read of the word starts now
                        end
                    end
                end
                ST_RETIRE:
                begin
                    lanes.wren <= LANES_NONE;   // write lands on this edge
                    o_ready    <= 1'b1;
                    if (op == OP_READ)
                    begin
                        o_rdata <= i_rdata_aligned;
                    end
                    state <= ST_DONE;
                end
                ST_DONE:
                begin
                    // hold the response while enable stays high
                    if (!i_enable)
                    begin
                        o_ready    <= 1'b0;
                        err_q      <= 1'b0;
                        lanes.wren <= LANES_NONE;
                        state      <= ST_ISSUE;
                    end
                end
                default:
                begin
                    state <= ST_ISSUE;
                end
            endcase
        end
    end

    // write payload, captured with the command
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            lanes.wdata <= i_wdata_steered;
        end
    end

endmodule

// ==== design/sp_bram_top.sv ====
// byte addressable block RAM peripheral
`include "sp_bram_settings.svh"

module sp_bram_top
    import bus_pkg::*,
           bram_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     i_enable,
    input  logic                     i_wr_en,
    input  logic [`SPB_ADDR_W-1:0]   i_addr,
    input  logic [`SPB_DATA_W-1:0]   i_wdata,
    input  logic [`SPB_DATA_W/8-1:0] i_be,
    output logic                     o_ready,
    output logic [`SPB_DATA_W-1:0]   o_rdata,
    output logic                     o_bus_err
);

    access_size_e               size;
    lane_mask_t                 lane_mask;
    logic [`SPB_DATA_W-1:0]     wdata_steered;
    logic [`SPB_DATA_W-1:0]     rdata_aligned;
    logic                       legal;

    lane_port_if lanes ();

    // bus address is held stable, so the lanes read it directly
    assign lanes.word_addr = i_addr[`SPB_WADDR_W+1:2];

    access_decode u_decode (
        .i_be            (i_be),
        .i_offset        (i_addr[1:0]),
        .i_wdata         (i_wdata),
        .o_size          (size),
        .o_lane_mask     (lane_mask),
        .o_wdata_steered (wdata_steered),
        .o_legal         (legal)
    );

    sp_bram_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_enable        (i_enable),
        .i_wr_en         (i_wr_en),
        .i_legal         (legal),
        .i_lane_mask     (lane_mask),
        .i_wdata_steered (wdata_steered),
        .i_rdata_aligned (rdata_aligned),
        .o_ready         (o_ready),
        .o_rdata         (o_rdata),
        .o_bus_err       (o_bus_err),
        .lanes           (lanes.ctrl)
    );

    lane_bank u_bank (
        .clk   (clk),
        .lanes (lanes.mem)
    );

    read_align u_align (
        .i_size          (size),
        .i_offset        (i_addr[1:0]),
        .lanes           (lanes.rd),
        .o_rdata_aligned (rdata_aligned)
    );

endmodule

// ==== bench/sp_bram_assert.sv ====
// handshake timing assertions
module sp_bram_assert
(
    input logic clk,
    input logic rst_n,
    input logic i_enable,
    input logic i_legal,
    input logic o_ready,
    input logic o_bus_err
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // outputs quiet on the edge after reset
    a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !o_ready && !o_bus_err)
    else
    begin
        fail_count++;
        $error("ready or error high right after reset");
    end

    a_legal_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(i_enable) && i_legal |=> !o_ready ##1 (o_ready && !o_bus_err))
    else
    begin
        fail_count++;
        $error("legal access did not complete two cycles after issue");
    end

    // refused at issue so only one cycle
    a_refused_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(i_enable) && !i_legal |=> o_ready && o_bus_err)
    else
    begin
        fail_count++;
        $error("illegal access not refused one cycle after issue");
    end

    a_ready_hold: assert property (@(posedge clk) disable iff (!rst_n)
        o_ready && i_enable |=> o_ready)
    else
    begin
        fail_count++;
        $error("ready dropped while enable still high");
    end

    a_ready_release: assert property (@(posedge clk) disable iff (!rst_n)
        o_ready && !i_enable |=> !o_ready)
    else
    begin
        fail_count++;
        $error("ready still high one edge after enable dropped");
    end

    // error only valid alongside ready
    a_err_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
        o_bus_err |-> o_ready)
    else
    begin
        fail_count++;
        $error("bus error high without ready");
    end

endmodule

// ==== bench/sp_bram_tb.sv ====
// sp_bram testbench
`include "sp_bram_settings.svh"

module sp_bram_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PERIOD  = 40;
    localparam int RST_CYC = 8;
    localparam int WORDS   = 64;    // size of the tested region
    localparam int N_RAND  = 240;
    localparam int N_BAD   = 12;
    localparam int HOLD    = 3;     // back-pressure on every eighth word access
    localparam int N_TRANS = 2 * WORDS + N_RAND + 2 * N_BAD;
    localparam int WATCHDOG_NS = 2 * (RST_CYC + 4 * N_TRANS + HOLD * WORDS / 4) * PERIOD;

    // {offset, mask} pairs the peripheral must refuse
    localparam logic [5:0] BAD_CASES [N_BAD] = '{
        6'b01_0011, 6'b11_0011,                 // misaligned halfwords
        6'b01_1111, 6'b10_1111, 6'b11_1111,     // misaligned words
        6'b00_0010, 6'b00_0110, 6'b11_1000, 6'b00_0111,
        6'b00_1110, 6'b00_0000, 6'b10_1100
    };

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     i_enable;
    logic                     i_wr_en;
    logic [`SPB_ADDR_W-1:0]   i_addr;
    logic [`SPB_DATA_W-1:0]   i_wdata;
    logic [`SPB_DATA_W/8-1:0] i_be;
    logic                     o_ready;
    logic [`SPB_DATA_W-1:0]   o_rdata;
    logic                     o_bus_err;

    logic [7:0] model [4*WORDS];   // byte image of the tested region
    int         errors = 0;
    int         checks = 0;
    int         test_err = 0;

    always #(PERIOD/2) clk = ~clk;

    sp_bram_top i_dut (.*);

    bind sp_bram_top sp_bram_assert u_assert (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_enable  (i_enable),
        .i_legal   (legal),
        .o_ready   (o_ready),
        .o_bus_err (o_bus_err)
    );

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // one bus command, optionally holding enable past ready
    task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] wdata, input int hold,
                              output logic [31:0] rdata, output logic err);
        int waited;
        @(posedge clk);
        i_enable <= 1'b1;
        i_wr_en  <= wr;
        i_addr   <= addr;
        i_be     <= be;
        i_wdata  <= wdata;
        waited = 0;
        do
        begin
            @(posedge clk);
            waited++;
        end
        while (!o_ready && waited < 8);
        if (!o_ready)
        begin
            errors++;
            $display("no ready within 8 cycles for the access at address %h", addr);
        end
        rdata = o_rdata;
        err   = o_bus_err;
        repeat (hold) @(posedge clk);
        i_enable <= 1'b0;
    endtask

    // legal masks are contiguous from bit 0, one bit per byte from the offset
    function automatic void model_write(input int a, input logic [3:0] be, input logic [31:0] d);
        for (int i = 0; i < 4; i++)
        begin
            if (be[i])
            begin
                model[a + i] = d[8*i +: 8];
            end
        end
    endfunction

    function automatic logic [31:0] model_read(input int a, input logic [3:0] be);
        logic [31:0] r;
        r = '0;   // zero-extended
        for (int i = 0; i < 4; i++)
        begin
            if (be[i])
            begin
                r[8*i +: 8] = model[a + i];
            end
        end
        return r;
    endfunction

    task automatic report_test(input string name);
        $display("%-16s done, %0d errors", name, errors - test_err);
        test_err = errors;
    endtask

    initial
    begin
        logic [31:0] rd;
        logic [31:0] data;
        logic [3:0]  be;
        logic        err;
        logic        wr;
        int          a;
        void'($urandom(32'hcdba_9449));
        rst_n    = 1'b0;
        i_enable = 1'b0;
        i_wr_en  = 1'b0;
        i_addr   = '0;
        i_wdata  = '0;
        i_be     = '0;
        repeat (RST_CYC) @(posedge clk);
        rst_n <= 1'b1;

        for (int w = 0; w < WORDS; w++)
        begin
            data = $urandom;
            bus_access(1'b1, 4*w, 4'b1111, data, (w % 8 == 0) ? HOLD : 0, rd, err);
            check_value("o_bus_err", 32'(err), 32'd0);
            model_write(4*w, 4'b1111, data);
        end
        for (int w = 0; w < WORDS; w++)
        begin
            bus_access(1'b0, 4*w, 4'b1111, '0, (w % 8 == 0) ? HOLD : 0, rd, err);
            check_value("o_bus_err", 32'(err), 32'd0);
            check_value("o_rdata", rd, model_read(4*w, 4'b1111));
        end
        report_test("word write/read");

        for (int n = 0; n < N_RAND; n++)
        begin
            be   = ($urandom_range(1) == 1) ? 4'b0011 : 4'b0001;
            a    = $urandom_range(4*WORDS - 1);
            wr   = ($urandom_range(1) == 1);
            data = $urandom;
            if (be == 4'b0011)
            begin
                a = a & ~1;   // halfword offsets 0 or 2
            end
            bus_access(wr, a, be, data, 0, rd, err);
            check_value("o_bus_err", 32'(err), 32'd0);
            if (wr)
            begin
                model_write(a, be, data);
            end
            else
            begin
                check_value("o_rdata", rd, model_read(a, be));
            end
        end
        report_test("byte/half random");

        for (int n = 0; n < N_BAD; n++)
        begin
            a = 4 * $urandom_range(WORDS - 1);
            bus_access(n % 2 == 0, a + int'(BAD_CASES[n][5:4]), BAD_CASES[n][3:0], $urandom, 0,
                       rd, err);
            check_value("o_bus_err", 32'(err), 32'd1);
            bus_access(1'b0, a, 4'b1111, '0, 0, rd, err);
            check_value("o_rdata", rd, model_read(a, 4'b1111));
        end
        report_test("illegal access");

        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, i_dut.u_assert.fail_count);
        if (errors == 0 && i_dut.u_assert.fail_count == 0)
        begin
            $display("TEST RESULT: PASS");
        end
        else
        begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("run stopped by the watchdog after %0d ns", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+design
design/bus_pkg.sv
design/bram_pkg.sv
design/lane_port_if.sv
design/access_decode.sv
design/lane_bank.sv
design/read_align.sv
design/sp_bram_ctrl.sv
design/sp_bram_top.sv
bench/sp_bram_assert.sv
bench/sp_bram_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --top-module sp_bram_tb -f list.f
	./obj_dir/Vsp_bram_tb +verilator+error+limit+1000 > $(LOG) 2>&1; \
	status=$$?; \
	cat $(LOG); \
	if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf obj_dir $(LOG)
